// File: src/lut_pkg.sv
package lut_pkg;

   // Entry and stream width
   localparam int DATA_W = 32;

   // One bus beat fills one RAM word
   localparam int BUS_DATA_W = 64;

   localparam int LANES = BUS_DATA_W / DATA_W;
   localparam int LANE_W = $clog2(LANES);

   // RAM word address, top bit selects the bank in ping-pong mode
   localparam int ADDR_W = 10;
   localparam int BANK_BIT = ADDR_W - 1;

   localparam int BUS_ADDR_W = 32;

   // Beat count minus one
   localparam int LEN_W = 8;

   typedef struct packed {
      logic [BUS_ADDR_W-1:0] ext_addr;
      logic [LEN_W-1:0]      length;
      logic                  ping_pong;
   } lut_cfg_t;

   typedef struct packed {
      logic                  en;
      logic [ADDR_W-1:0]     addr;
      logic [BUS_DATA_W-1:0] data;
   } ram_wr_t;

endpackage

// File: src/table_loader.sv
`timescale 1ns/1ps

module table_loader (
   input  logic                               clk,
   input  logic                               rst,
   input  logic                               run,
   input  lut_pkg::lut_cfg_t                  cfg,

   // Read bus
   output logic                               bus_valid,
   output logic [lut_pkg::BUS_ADDR_W-1:0]     bus_addr,
   output logic [lut_pkg::LEN_W-1:0]          bus_len,
   input  logic                               bus_ready,
   input  logic [lut_pkg::BUS_DATA_W-1:0]     bus_rdata,
   input  logic                               bus_last,

   output logic                               done,
   output logic                               bank,
   output lut_pkg::ram_wr_t                   ram_wr
);

   logic                             beat;
   logic                             last_beat;
   logic [lut_pkg::ADDR_W-1:0]       wr_cnt;
   logic [lut_pkg::ADDR_W-1:0]       wr_addr_next;

   logic                             wr_en;
   logic [lut_pkg::ADDR_W-1:0]       wr_addr;
   logic [lut_pkg::BUS_DATA_W-1:0]   wr_data;

   assign beat      = bus_valid && bus_ready;
   assign last_beat = beat && bus_last;

   // Burst length comes straight from the configuration
   assign bus_len = cfg.length;

   // Request level, done flag and captured address
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bus_valid <= 1'b0;
         done      <= 1'b1;
         bus_addr  <= '0;
      end else if (run) begin
         bus_valid <= 1'b1;
         done      <= 1'b0;
         bus_addr  <= cfg.ext_addr;
      end else if (last_beat) begin
         bus_valid <= 1'b0;
         done      <= 1'b1;
      end
   end

   // Bank flips per run in ping-pong mode, otherwise stays at 0
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bank <= 1'b0;
      end else if (run) begin
         bank <= cfg.ping_pong ? ~bank : 1'b0;
      end
   end

   // Word counter steps once per counted beat
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_cnt <= '0;
      end else if (run) begin
         wr_cnt <= '0;
      end else if (beat) begin
         wr_cnt <= wr_cnt + 1'b1;
      end
   end

   // Write bank goes on top of the word address
   always_comb begin
      wr_addr_next = wr_cnt;
      if (cfg.ping_pong) begin
         wr_addr_next[lut_pkg::BANK_BIT] = bank;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_en <= 1'b0;
      end else begin
         wr_en <= beat;
      end
   end

   always_ff @(posedge clk) begin
      if (beat) begin
         wr_addr <= wr_addr_next;
         wr_data <= bus_rdata;
      end
   end

   assign ram_wr = '{en: wr_en, addr: wr_addr, data: wr_data};

   // The bus model may only deliver while a request is open
   a_ready_needs_valid : assert property (
      @(posedge clk) disable iff (rst)
      bus_ready |-> bus_valid
   ) else $error("bus_ready seen with bus_valid low");

   // A burst must fit in one bank when the RAM is split
   a_cnt_within_bank : assert property (
      @(posedge clk) disable iff (rst)
      (bus_valid && cfg.ping_pong) |-> !wr_cnt[lut_pkg::BANK_BIT]
   ) else $error("burst overruns the ping-pong bank");

endmodule

// File: src/lut_ram.sv
`timescale 1ns/1ps

module lut_ram (
   input  logic                               clk,
   input  logic                               rst,
   input  lut_pkg::ram_wr_t                   ram_wr,
   input  logic [lut_pkg::ADDR_W-1:0]         rd_addr,
   output logic [lut_pkg::BUS_DATA_W-1:0]     rd_data
);

   localparam int DEPTH = 2 ** lut_pkg::ADDR_W;

   logic [lut_pkg::BUS_DATA_W-1:0] mem [DEPTH];

   // Write port, fed by the loader
   always_ff @(posedge clk) begin
      if (ram_wr.en) begin
         mem[ram_wr.addr] <= ram_wr.data;
      end
   end

   // Registered read port for lookups
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_data <= '0;
      end else begin
         rd_data <= mem[rd_addr];
      end
   end

   // Loader and lookup only meet in bank 0, which is the shared
   // non-ping-pong layout. In ping-pong mode they sit in opposite banks.
   a_no_bank1_collision : assert property (
      @(posedge clk) disable iff (rst)
      (ram_wr.en && (ram_wr.addr == rd_addr)) |-> !ram_wr.addr[lut_pkg::BANK_BIT]
   ) else $error("read and write collide inside a ping-pong bank");

endmodule

// File: src/lut_lookup.sv
`timescale 1ns/1ps

module lut_lookup (
   input  logic                               clk,
   input  logic                               rst,
   input  logic [lut_pkg::DATA_W-1:0]         in0,
   input  logic                               cfg_ping_pong,
   input  logic                               bank,
   output logic [lut_pkg::ADDR_W-1:0]         rd_addr,
   input  logic [lut_pkg::BUS_DATA_W-1:0]     rd_data,
   output logic [lut_pkg::DATA_W-1:0]         out0
);

   localparam int WORD_IDX_W = lut_pkg::ADDR_W - lut_pkg::LANE_W;

   logic [lut_pkg::ADDR_W-1:0]                   rd_addr_next;
   logic [lut_pkg::LANE_W-1:0]                   lane_q1;
   logic [lut_pkg::LANE_W-1:0]                   lane_q2;
   logic [lut_pkg::LANES-1:0][lut_pkg::DATA_W-1:0] word_lanes;

   // Drop the lane bits, then put the read bank on top
   always_comb begin
      rd_addr_next = '0;
      rd_addr_next[WORD_IDX_W-1:0] = in0[lut_pkg::ADDR_W-1:lut_pkg::LANE_W];
      rd_addr_next[lut_pkg::BANK_BIT] = cfg_ping_pong && !bank;
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_addr <= '0;
      end else begin
         rd_addr <= rd_addr_next;
      end
   end

   // Lane select follows the index through the RAM latency
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         lane_q1 <= '0;
         lane_q2 <= '0;
      end else begin
         lane_q1 <= in0[lut_pkg::LANE_W-1:0];
         lane_q2 <= lane_q1;
      end
   end

   // Lane 0 is the low half of the word
   assign word_lanes = rd_data;
   assign out0 = word_lanes[lane_q2];

endmodule

// File: src/lut_read.sv
`timescale 1ns/1ps

module lut_read (
   input  logic                               clk,
   input  logic                               rst,
   input  logic                               run,
   input  lut_pkg::lut_cfg_t                  cfg,

   // Lookup stream
   input  logic [lut_pkg::DATA_W-1:0]         in0,
   output logic [lut_pkg::DATA_W-1:0]         out0,

   output logic                               done,

   // Read bus
   output logic                               bus_valid,
   output logic [lut_pkg::BUS_ADDR_W-1:0]     bus_addr,
   output logic [lut_pkg::LEN_W-1:0]          bus_len,
   input  logic                               bus_ready,
   input  logic [lut_pkg::BUS_DATA_W-1:0]     bus_rdata,
   input  logic                               bus_last
);

   lut_pkg::ram_wr_t                   ram_wr;
   logic                               bank;
   logic [lut_pkg::ADDR_W-1:0]         rd_addr;
   logic [lut_pkg::BUS_DATA_W-1:0]     rd_data;

   table_loader table_loader_inst (
      .clk       (clk),
      .rst       (rst),
      .run       (run),
      .cfg       (cfg),
      .bus_valid (bus_valid),
      .bus_addr  (bus_addr),
      .bus_len   (bus_len),
      .bus_ready (bus_ready),
      .bus_rdata (bus_rdata),
      .bus_last  (bus_last),
      .done      (done),
      .bank      (bank),
      .ram_wr    (ram_wr)
   );

   lut_ram lut_ram_inst (
      .clk     (clk),
      .rst     (rst),
      .ram_wr  (ram_wr),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   lut_lookup lut_lookup_inst (
      .clk           (clk),
      .rst           (rst),
      .in0           (in0),
      .cfg_ping_pong (cfg.ping_pong),
      .bank          (bank),
      .rd_addr       (rd_addr),
      .rd_data       (rd_data),
      .out0          (out0)
   );

endmodule

// File: test/lut_checker.sv
`timescale 1ns/1ps

module lut_checker (
   input  logic                               clk,
   input  logic                               rst,
   input  logic                               run,
   input  lut_pkg::lut_cfg_t                  cfg,
   input  logic [lut_pkg::DATA_W-1:0]         in0,
   input  logic                               check_on,
   input  logic [lut_pkg::DATA_W-1:0]         out0,
   input  logic                               done,
   input  logic                               bus_valid,
   input  logic [lut_pkg::BUS_ADDR_W-1:0]     bus_addr,
   input  logic [lut_pkg::LEN_W-1:0]          bus_len,
   input  logic                               bus_ready,
   input  logic [lut_pkg::BUS_DATA_W-1:0]     bus_rdata,
   input  logic                               bus_last,
   output int                                 err_cnt
);

   // Copy of the table RAM, both banks
   logic [lut_pkg::BUS_DATA_W-1:0] ref_mem [2 ** lut_pkg::ADDR_W];

   logic                             ref_bank;
   logic                             done_exp;
   logic                             beat;
   int                               beat_cnt;
   int                               beats_exp;
   logic                             pend_en;
   logic [lut_pkg::ADDR_W-1:0]       pend_addr;
   logic [lut_pkg::BUS_DATA_W-1:0]   pend_data;
   logic [lut_pkg::ADDR_W-1:0]       beat_addr;

   // Two-deep queue of lookups in flight
   logic                             s1_valid;
   logic [lut_pkg::DATA_W-1:0]       s1_idx;
   logic                             s1_rbank;
   logic                             s2_valid;
   logic [lut_pkg::DATA_W-1:0]       s2_exp;

   // Upper index bits give the word, bit 0 the lane, lane 0 is the low half
   function automatic logic [lut_pkg::DATA_W-1:0] ref_entry(
      input logic [lut_pkg::DATA_W-1:0] idx,
      input logic                       rbank
   );
      logic [lut_pkg::ADDR_W-1:0]     word_addr;
      logic [lut_pkg::BUS_DATA_W-1:0] word;
      word_addr = idx[lut_pkg::ADDR_W:lut_pkg::LANE_W];
      word_addr[lut_pkg::BANK_BIT] = rbank;
      word = ref_mem[word_addr];
      if (idx[0]) begin
         return word[lut_pkg::DATA_W +: lut_pkg::DATA_W];
      end
      return word[0 +: lut_pkg::DATA_W];
   endfunction

   task automatic report_value(input string name, input logic [63:0] exp,
                               input logic [63:0] got);
      $display("[FAIL] %0t ns %s expected %0h actual %0h", $time, name, exp, got);
      err_cnt = err_cnt + 1;
   endtask

   always @(posedge clk or posedge rst) begin
      if (rst) begin
         err_cnt  = 0;
         ref_bank = 1'b0;
         done_exp = 1'b1;
         beat_cnt = 0;
         pend_en  = 1'b0;
         s1_valid = 1'b0;
         s2_valid = 1'b0;
      end else begin
         if (s2_valid && (out0 !== s2_exp)) begin
            report_value("out0", 64'(s2_exp), 64'(out0));
         end
         // RAM is read one edge after the index, before this edge's write
         s2_valid = s1_valid;
         s2_exp   = ref_entry(s1_idx, s1_rbank);
         s1_valid = check_on;
         s1_idx   = in0;
         s1_rbank = cfg.ping_pong && !ref_bank;
         if (pend_en) begin
            ref_mem[pend_addr] = pend_data;
         end

         if (done !== done_exp) begin
            report_value("done", 64'(done_exp), 64'(done));
         end
         if (bus_valid !== !done_exp) begin
            report_value("bus_valid", 64'(!done_exp), 64'(bus_valid));
         end
         if (!done_exp && (bus_addr !== cfg.ext_addr)) begin
            report_value("bus_addr", 64'(cfg.ext_addr), 64'(bus_addr));
         end
         if (!done_exp && (bus_len !== cfg.length)) begin
            report_value("bus_len", 64'(cfg.length), 64'(bus_len));
         end

         beat = !done_exp && bus_ready;
         beat_addr = beat_cnt[lut_pkg::ADDR_W-1:0];
         if (cfg.ping_pong) begin
            beat_addr[lut_pkg::BANK_BIT] = ref_bank;
         end
         pend_en   = beat;
         pend_addr = beat_addr;
         pend_data = bus_rdata;
         if (beat) begin
            beat_cnt = beat_cnt + 1;
         end
         if (beat && bus_last) begin
            beats_exp = int'(cfg.length) + 1;
            if (beat_cnt != beats_exp) begin
               report_value("beat count", 64'(beats_exp), 64'(beat_cnt));
            end
            done_exp = 1'b1;
         end
         if (run) begin
            done_exp = 1'b0;
            beat_cnt = 0;
            ref_bank = cfg.ping_pong ? !ref_bank : 1'b0;
         end
      end
   end

endmodule

// File: test/tb_lut_read.sv
`timescale 1ns/1ps

module tb_lut_read;

   localparam int BEATS = 64;
   localparam int POOL = 1024;
   localparam int LOAD_CYCLES = 4 * BEATS + 20;
   localparam int TEST_CYCLES = 10 + LOAD_CYCLES + 2 * 200 + 100 + 3 * (LOAD_CYCLES + 40);
   localparam int CYCLE_LIMIT = 2 * TEST_CYCLES + 200;

   logic                               clk = 1'b0;
   logic                               rst;
   logic                               run;
   lut_pkg::lut_cfg_t                  cfg;
   logic [lut_pkg::DATA_W-1:0]         in0;
   logic [lut_pkg::DATA_W-1:0]         out0;
   logic                               done;
   logic                               bus_valid;
   logic [lut_pkg::BUS_ADDR_W-1:0]     bus_addr;
   logic [lut_pkg::LEN_W-1:0]          bus_len;
   logic                               bus_ready = 1'b0;
   logic [lut_pkg::BUS_DATA_W-1:0]     bus_rdata = '0;
   logic                               bus_last = 1'b0;

   logic                               check_on;
   int                                 err_cnt;
   int                                 misc_err = 0;
   int                                 tests_passed = 0;
   int                                 tests_failed = 0;
   int                                 cycles = 0;
   logic [31:0]                        lfsr = 32'hf76aad3d;
   logic [lut_pkg::BUS_DATA_W-1:0]     ext_mem [256];
   logic [lut_pkg::DATA_W-1:0]         idx_pool [POOL];
   logic [9:0]                         pool_ptr = '0;
   logic [7:0]                         beat_idx = '0;
   logic [1:0]                         lanes_seen = '0;

   lut_read lut_read_inst (
      .clk(clk), .rst(rst), .run(run), .cfg(cfg), .in0(in0), .out0(out0), .done(done),
      .bus_valid(bus_valid), .bus_addr(bus_addr), .bus_len(bus_len),
      .bus_ready(bus_ready), .bus_rdata(bus_rdata), .bus_last(bus_last)
   );

   lut_checker lut_checker_inst (
      .clk(clk), .rst(rst), .run(run), .cfg(cfg), .in0(in0), .check_on(check_on),
      .out0(out0), .done(done), .bus_valid(bus_valid), .bus_addr(bus_addr),
      .bus_len(bus_len), .bus_ready(bus_ready), .bus_rdata(bus_rdata),
      .bus_last(bus_last), .err_cnt(err_cnt)
   );

   always #2 clk = ~clk;

   // Galois form, taps for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   function automatic logic [63:0] take_bits(input int n);
      logic [63:0] v;
      int          i;
      v = '0;
      for (i = 0; i < n; i++) begin
         v = {v[62:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
      return v;
   endfunction

   // Bus memory model, one random bit per cycle decides whether a beat goes out
   always @(negedge clk) begin
      if (rst || !bus_valid) begin
         bus_ready = 1'b0;
         bus_last = 1'b0;
         beat_idx = '0;
      end else if (take_bits(1) != 64'd0) begin
         bus_ready = 1'b1;
         bus_rdata = ext_mem[bus_addr[10:3] + beat_idx];
         bus_last = (beat_idx == bus_len);
         beat_idx = beat_idx + 8'd1;
      end else begin
         bus_ready = 1'b0;
         bus_last = 1'b0;
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout: the run passed %0d cycles without finishing", cycles);
         $display("Something failed");
         $finish;
      end
   end

   task automatic drive_lookup(input logic on);
      if (on) begin
         in0 = idx_pool[pool_ptr];
         pool_ptr = pool_ptr + 10'd1;
         check_on = 1'b1;
         lanes_seen[in0[0]] = 1'b1;
      end else begin
         in0 = '0;
         check_on = 1'b0;
      end
   endtask

   // Called on a falling edge; returns on the falling edge where done is back
   task automatic load_table(input logic [7:0] ext_word, input logic pp, input logic look);
      cfg.ext_addr = {21'd0, ext_word, 3'd0};
      cfg.length = 8'(BEATS - 1);
      cfg.ping_pong = pp;
      run = 1'b1;
      drive_lookup(1'b0);
      @(negedge clk);
      run = 1'b0;
      while (!done) begin
         drive_lookup(look);
         @(negedge clk);
      end
   endtask

   task automatic lookup_for(input int n);
      repeat (n) begin
         drive_lookup(1'b1);
         @(negedge clk);
      end
   endtask

   task automatic end_test(input string name, input int errs_before);
      if (err_cnt + misc_err == errs_before) begin
         tests_passed++;
         $display("test %s passed", name);
      end else begin
         tests_failed++;
         $display("test %s failed with %0d errors", name, err_cnt + misc_err - errs_before);
      end
   endtask

   initial begin
      int errs_before;
      rst = 1'b1;
      run = 1'b0;
      cfg = '0;
      in0 = '0;
      check_on = 1'b0;
      foreach (ext_mem[i]) ext_mem[i] = take_bits(64);
      // Indices stay inside the 128 entries of one table
      foreach (idx_pool[i]) idx_pool[i] = 32'(take_bits(7));
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      errs_before = err_cnt + misc_err;
      repeat (5) @(negedge clk);
      end_test("reset state", errs_before);

      errs_before = err_cnt + misc_err;
      load_table(8'd0, 1'b0, 1'b0);
      repeat (2) @(negedge clk);
      end_test("table load", errs_before);

      errs_before = err_cnt + misc_err;
      lanes_seen = '0;
      repeat (200) begin
         drive_lookup(1'b1);
         @(negedge clk);
         drive_lookup(1'b0);
         @(negedge clk);
      end
      repeat (3) @(negedge clk);
      if (lanes_seen != 2'b11) begin
         $display("Spaced lookups did not use both lanes of a word");
         misc_err++;
      end
      end_test("spaced lookups", errs_before);

      errs_before = err_cnt + misc_err;
      lookup_for(100);
      drive_lookup(1'b0);
      repeat (3) @(negedge clk);
      end_test("back-to-back lookups", errs_before);

      // Tables A, B, then C into A's bank
      errs_before = err_cnt + misc_err;
      load_table(8'd64, 1'b1, 1'b1);
      lookup_for(40);
      load_table(8'd128, 1'b1, 1'b1);
      lookup_for(40);
      load_table(8'd192, 1'b1, 1'b1);
      lookup_for(40);
      drive_lookup(1'b0);
      repeat (3) @(negedge clk);
      end_test("ping-pong banks", errs_before);

      $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
      if (tests_failed == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// File: vlog.f
src/lut_pkg.sv
src/table_loader.sv
src/lut_ram.sv
src/lut_lookup.sv
src/lut_read.sv
test/lut_checker.sv
test/tb_lut_read.sv

// File: run.sh
#!/bin/sh
# Build and run the lut_read testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_lut_read -f vlog.f -o sim_lut_read \
   && ./obj_dir/sim_lut_read | tee sim.log \
   || echo "build or simulation stopped with an error"

grep -q "^Everything OK$" sim.log 2>/dev/null && echo "PASS" && exit 0
echo "FAIL"
exit 1
